// File: afuCsr.sv
// afu CSR block, holds the feature header, ID words and scratch register
`timescale 1ns/1ps

module afuCsr
        import afuPkg::*;
(
        input  logic    Clk_400,
        input  logic    reset,
        input  tMmioReq req,
        output tMmioRsp rsp,
        output logic    rspValid
);

        // ********************************************************************
        // registers
        // ********************************************************************

        // the only writable register
        logic [63:0] scratch;

        // read data selected from the address
        logic [63:0] readData;

        // request qualifiers
        logic        isRead;
        logic        isWrite;
        logic        hitScratch;

        assign isRead     = (req.op == opRead);
        assign isWrite    = (req.op == opWrite);
        assign hitScratch = (req.addr == csrScratch);

        // write path
        // writes to any other address are ignored
        always_ff @(posedge Clk_400) begin
                if (reset) begin
                        scratch <= 64'h0;
                end else if (isWrite && hitScratch) begin
                        scratch <= req.data;
                end
        end

        // ********************************************************************
        // read decode
        // ********************************************************************

        always_comb begin
                case (tCsrAddr'(req.addr))
                        // feature header
                        csrDfh: begin
                                readData = DfhValue;
                        end
                        // id words
                        csrIdLo: begin
                                readData = AfuIdLo;
                        end
                        csrIdHi: begin
                                readData = AfuIdHi;
                        end
                        // no further afu in the list
                        csrNextAfu: begin
                                readData = 64'h0;
                        end
                        csrRsvd: begin
                                readData = 64'h0;
                        end
                        csrScratch: begin
                                readData = scratch;
                        end
                        // unmapped addresses read as zero
                        default: begin
                                readData = 64'h0;
                        end
                endcase
        end

        // ********************************************************************
        // response
        // ********************************************************************

        // valid pulse, one cycle after the request
        always_ff @(posedge Clk_400) begin
                if (reset) begin
                        rspValid <= 1'b0;
                end else begin
                        rspValid <= isRead;
                end
        end

        // response payload, tid echoed
        always_ff @(posedge Clk_400) begin
                if (isRead) begin
                        rsp.tid  <= req.tid;
                        rsp.data <= readData;
                end
        end

endmodule

// File: afuPkg.sv
// afu package with the port structs, request and response records, opcodes and CSR map
package afuPkg;

        // ********************************************************************
        // host port records
        // ********************************************************************

        // mmio request header, quadword address
        typedef struct packed {
                logic [15:0] address;
                logic [1:0]  length;
                logic [8:0]  tid;
        } tMmioHdr;

        // receive port, header plus full line of data and the two strobes
        typedef struct packed {
                tMmioHdr      hdr;
                logic [511:0] data;
                logic         mmioRdValid;
                logic         mmioWrValid;
        } tRxPort;

        // transmit response channel, one valid pulse per read response
        typedef struct packed {
                logic [8:0]  tid;
                logic [63:0] data;
                logic        mmioRdValid;
        } tTxPort;

        // ********************************************************************
        // internal records
        // ********************************************************************

        // request kind after decode
        typedef enum logic [1:0] {
                opNone  = 2'd0,
                opRead  = 2'd1,
                opWrite = 2'd2
        } tReqOp;

        // decoded request, only the low quadword of data is kept
        typedef struct packed {
                tReqOp       op;
                logic [15:0] addr;
                logic [8:0]  tid;
                logic [63:0] data;
        } tMmioReq;

        // read response, tid echoed from the request
        typedef struct packed {
                logic [8:0]  tid;
                logic [63:0] data;
        } tMmioRsp;

        // mapped quadword addresses
        typedef enum logic [15:0] {
                csrDfh     = 16'h0000,
                csrIdLo    = 16'h0002,
                csrIdHi    = 16'h0004,
                csrNextAfu = 16'h0006,
                csrRsvd    = 16'h0008,
                csrScratch = 16'h0020
        } tCsrAddr;

        // afu identity, 128 bits split in two words
        localparam logic [63:0] AfuIdLo = 64'h5C3E_91A7_0D44_B286;
        localparam logic [63:0] AfuIdHi = 64'h27F1_6B0A_E953_4C1D;

        // device feature header
        localparam logic [63:0] DfhValue = {
                4'b0001,        // feature type afu
                8'b0,
                4'b0,           // minor revision
                7'b0,
                1'b1,           // last entry in the list
                24'b0,          // next offset
                4'b0,           // major revision
                12'b0           // feature id
        };

endpackage

// File: afuTb.sv
// afu testbench, host model issuing mmio traffic and a checker on the response channel
`timescale 1ns/1ps

module afuTb
        import afuPkg::*;
;

        localparam int RspDepth = 8;
        localparam int RspGap   = 2;

        logic   Clk_400;
        logic   reset;
        tRxPort rxPort;
        tTxPort txPort;

        // expected responses in request order
        tMmioRsp     expQ [$];
        logic [63:0] scratchModel;
        int          issuedCnt;
        int          cycleCnt;
        int          lastRspCycle;
        logic [15:0] mappedAddr [6] = '{csrDfh, csrIdLo, csrIdHi, csrNextAfu, csrRsvd, csrScratch};

        afuTop #(
                .RspDepth (RspDepth),
                .RspGap   (RspGap)
        ) dut (
                .Clk_400 (Clk_400),
                .reset   (reset),
                .rxPort  (rxPort),
                .txPort  (txPort)
        );

        // 100 ns period
        always #50 Clk_400 = ~Clk_400;

        always @(posedge Clk_400) begin
                cycleCnt <= cycleCnt + 1;
        end

        // ********************************************************************
        // reference model and checks
        // ********************************************************************

        // expected read data from the CSR map, unmapped reads as zero
        function automatic logic [63:0] refRead(input logic [15:0] addr,
                                                input logic [63:0] scratchVal);
                case (addr)
                        csrDfh:     return DfhValue;
                        csrIdLo:    return AfuIdLo;
                        csrIdHi:    return AfuIdHi;
                        csrScratch: return scratchVal;
                        default:    return 64'h0;
                endcase
        endfunction

        function automatic bit isMapped(input logic [15:0] addr);
                foreach (mappedAddr[i]) begin
                        if (mappedAddr[i] == addr) begin
                                return 1'b1;
                        end
                end
                return 1'b0;
        endfunction

        task automatic endFailed();
                $display("Verification failed");
                $fatal(1, "stopped at first error");
        endtask

        task automatic reportError(input string msg);
                $display("ERROR: %s", msg);
                endFailed();
        endtask

        task automatic checkVal(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
                if (got !== exp) begin
                        $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
                        endFailed();
                end
        endtask

        // one response per pulse, sampled mid-cycle where txPort is stable
        always @(negedge Clk_400) begin
                tMmioRsp exp;
                if (!reset && txPort.mmioRdValid) begin
                        if (cycleCnt - lastRspCycle < RspGap) begin
                                reportError("response pulses closer than the minimum gap");
                        end
                        lastRspCycle = cycleCnt;
                        if (expQ.size() == 0) begin
                                reportError("response arrived with no read outstanding");
                        end
                        exp = expQ.pop_front();
                        checkVal("txPort.tid", 64'(txPort.tid), 64'(exp.tid));
                        checkVal("txPort.data", txPort.data, exp.data);
                end
        end

        // limit grows with the traffic issued so far
        always @(negedge Clk_400) begin
                if (cycleCnt > 10 * issuedCnt + 200) begin
                        reportError("timeout waiting for responses");
                end
        end

        // ********************************************************************
        // host model
        // ********************************************************************

        task automatic driveReq(input logic rd, input logic wr, input logic [15:0] addr,
                                input logic [8:0] tid, input logic [511:0] data);
                tRxPort pkt;
                pkt.hdr.address = addr;
                pkt.hdr.length  = 2'b00;
                pkt.hdr.tid     = tid;
                pkt.data        = data;
                pkt.mmioRdValid = rd;
                pkt.mmioWrValid = wr;
                @(posedge Clk_400);
                rxPort <= pkt;
        endtask

        task automatic idleCycle();
                driveReq(1'b0, 1'b0, 16'h0, 9'h0, '0);
        endtask

        function automatic logic [511:0] randomLine();
                logic [511:0] line;
                for (int i = 0; i < 16; i++) begin
                        line[i*32 +: 32] = $urandom();
                end
                return line;
        endfunction

        function automatic logic [15:0] randomUnmapped();
                logic [15:0] addr;
                do begin
                        addr = 16'($urandom());
                end while (isMapped(addr));
                return addr;
        endfunction

        // host keeps at most RspDepth reads in flight
        task automatic readCsr(input logic [15:0] addr);
                tMmioRsp exp;
                while (expQ.size() >= RspDepth) begin
                        idleCycle();
                end
                exp.tid  = 9'($urandom());
                exp.data = refRead(addr, scratchModel);
                expQ.push_back(exp);
                issuedCnt++;
                driveReq(1'b1, 1'b0, addr, exp.tid, randomLine());
        endtask

        task automatic writeCsr(input logic [15:0] addr, input logic [511:0] line);
                issuedCnt++;
                if (addr == csrScratch) begin
                        scratchModel = line[63:0];
                end
                driveReq(1'b0, 1'b1, addr, 9'($urandom()), line);
        endtask

        task automatic drainResponses();
                idleCycle();
                while (expQ.size() != 0) begin
                        @(posedge Clk_400);
                end
        endtask

        // ********************************************************************
        // test sequence
        // ********************************************************************

        initial begin
                logic [511:0] line;
                void'($urandom(32'hde92));
                Clk_400      = 1'b0;
                reset        = 1'b1;
                rxPort       = '0;
                scratchModel = 64'h0;
                issuedCnt    = 0;
                cycleCnt     = 0;
                lastRspCycle = -1000;
                repeat (8) @(posedge Clk_400);
                reset <= 1'b0;

                // reset values of the whole map
                foreach (mappedAddr[i]) begin
                        readCsr(mappedAddr[i]);
                end
                drainResponses();

                // scratch write then read in the next cycle, upper line bits random
                repeat (4) begin
                        line = randomLine();
                        writeCsr(csrScratch, line);
                        readCsr(csrScratch);
                end
                drainResponses();

                // unmapped reads, then writes to read-only and unmapped addresses
                repeat (8) readCsr(randomUnmapped());
                for (int i = 0; i < 5; i++) begin
                        writeCsr(mappedAddr[i], randomLine());
                end
                writeCsr(randomUnmapped(), randomLine());
                foreach (mappedAddr[i]) begin
                        readCsr(mappedAddr[i]);
                end
                drainResponses();

                // back-to-back burst filling the FIFO depth
                repeat (RspDepth) readCsr(mappedAddr[$urandom_range(5, 0)]);
                drainResponses();

                // catch any late or spurious response
                repeat (20) @(posedge Clk_400);
                $display("Verification passed");
                $finish;
        end

endmodule

// File: afuTop.sv
// afu top level, connects mmio ingress, CSR block, response FIFO and egress
`timescale 1ns/1ps

module afuTop
        import afuPkg::*;
#(
        parameter int RspDepth = 8,
        parameter int RspGap   = 2
) (
        input  logic   Clk_400,
        input  logic   reset,
        input  tRxPort rxPort,
        output tTxPort txPort
);

        // ********************************************************************
        // internal links
        // ********************************************************************

        // ingress to csr
        tMmioReq req;

        // csr to fifo
        tMmioRsp rsp;
        logic    rspValid;

        // fifo to egress
        tMmioRsp head;
        logic    notEmpty;
        logic    pop;

        // request decode, one cycle latency
        mmioIngress uIngress (
                .Clk_400 (Clk_400),
                .reset   (reset),
                .rxPort  (rxPort),
                .req     (req)
        );

        // register file and read response build
        afuCsr uCsr (
                .Clk_400  (Clk_400),
                .reset    (reset),
                .req      (req),
                .rsp      (rsp),
                .rspValid (rspValid)
        );

        // absorbs read bursts, host keeps at most RspDepth outstanding
        rspFifo #(
                .RspDepth (RspDepth)
        ) uFifo (
                .Clk_400  (Clk_400),
                .reset    (reset),
                .push     (rspValid),
                .wrRsp    (rsp),
                .pop      (pop),
                .head     (head),
                .notEmpty (notEmpty)
        );

        // paced response channel
        rspEgress #(
                .RspGap (RspGap)
        ) uEgress (
                .Clk_400  (Clk_400),
                .reset    (reset),
                .head     (head),
                .notEmpty (notEmpty),
                .pop      (pop),
                .txPort   (txPort)
        );

endmodule

// File: mmioIngress.sv
// mmio ingress, registers the receive port and decodes it into a request record
`timescale 1ns/1ps

module mmioIngress
        import afuPkg::*;
(
        input  logic    Clk_400,
        input  logic    reset,
        input  tRxPort  rxPort,
        output tMmioReq req
);

        // ********************************************************************
        // input register stage
        // ********************************************************************

        // registered strobes
        logic        rdValidQ;
        logic        wrValidQ;

        // registered header fields and low quadword
        logic [15:0] addrQ;
        logic [8:0]  tidQ;
        logic [63:0] dataQ;

        // request strobes, low after reset
        always_ff @(posedge Clk_400) begin
                if (reset) begin
                        rdValidQ <= 1'b0;
                        wrValidQ <= 1'b0;
                end else begin
                        rdValidQ <= rxPort.mmioRdValid;
                        wrValidQ <= rxPort.mmioWrValid;
                end
        end

        // payload captured every cycle
        always_ff @(posedge Clk_400) begin
                addrQ <= rxPort.hdr.address;
                tidQ  <= rxPort.hdr.tid;
                // upper part of the line is not used by any register
                dataQ <= rxPort.data[63:0];
        end

        // ********************************************************************
        // decode
        // ********************************************************************

        always_comb begin
                // read has priority, a write in the same cycle is lost
                if (rdValidQ) begin
                        req.op = opRead;
                end else if (wrValidQ) begin
                        req.op = opWrite;
                end else begin
                        req.op = opNone;
                end
                req.addr = addrQ;
                req.tid  = tidQ;
                req.data = dataQ;
        end

endmodule

// File: rspEgress.sv
// response egress, pops the FIFO at a paced rate and drives the response channel
`timescale 1ns/1ps

module rspEgress
        import afuPkg::*;
#(
        parameter int RspGap = 2
) (
        input  logic    Clk_400,
        input  logic    reset,
        input  tMmioRsp head,
        input  logic    notEmpty,
        output logic    pop,
        output tTxPort  txPort
);

        localparam int GapWidth = $clog2(RspGap + 1);

        // egIdle may send, egHold waits out the gap
        typedef enum logic {
                egIdle = 1'b0,
                egHold = 1'b1
        } tEgState;

        tEgState               state;
        logic [GapWidth-1:0]   gapCnt;

        // ********************************************************************
        // pacing
        // ********************************************************************

        // pop as soon as an entry is waiting and no gap is pending
        assign pop = (state == egIdle) && notEmpty;

        always_ff @(posedge Clk_400) begin
                if (reset) begin
                        // first response goes out without delay
                        state  <= egIdle;
                        gapCnt <= '0;
                end else if (state == egIdle) begin
                        if (pop && (RspGap > 1)) begin
                                state  <= egHold;
                                gapCnt <= GapWidth'(RspGap - 1);
                        end
                end else begin
                        // hold for RspGap-1 cycles after each pop
                        if (gapCnt <= GapWidth'(1)) begin
                                state <= egIdle;
                        end
                        gapCnt <= gapCnt - 1'b1;
                end
        end

        // registered response channel, one-cycle valid
        always_ff @(posedge Clk_400) begin
                if (reset) begin
                        txPort <= '0;
                end else begin
                        txPort.mmioRdValid <= pop;
                        if (pop) begin
                                txPort.tid  <= head.tid;
                                txPort.data <= head.data;
                        end
                end
        end

endmodule

// File: rspFifo.sv
// response FIFO, show-ahead buffer of pending read responses in request order
`timescale 1ns/1ps

module rspFifo
        import afuPkg::*;
#(
        parameter int RspDepth = 8
) (
        input  logic    Clk_400,
        input  logic    reset,
        input  logic    push,
        input  tMmioRsp wrRsp,
        input  logic    pop,
        output tMmioRsp head,
        output logic    notEmpty
);

        // pointer and count widths
        localparam int PtrWidth = (RspDepth > 1) ? $clog2(RspDepth) : 1;
        localparam int CntWidth = $clog2(RspDepth + 1);

        // ********************************************************************
        // storage and pointers
        // ********************************************************************

        tMmioRsp               mem [RspDepth];
        logic [PtrWidth-1:0]   wrPtr;
        logic [PtrWidth-1:0]   rdPtr;
        logic [CntWidth-1:0]   count;

        logic                  full;
        logic                  doPush;
        logic                  doPop;

        assign full     = (count == CntWidth'(RspDepth));
        assign notEmpty = (count != '0);

        // push while full is dropped
        assign doPush = push && !full;
        assign doPop  = pop && notEmpty;

        // show-ahead, head is the oldest entry
        assign head = mem[rdPtr];

        // storage write
        always_ff @(posedge Clk_400) begin
                if (doPush) begin
                        mem[wrPtr] <= wrRsp;
                end
        end

        // pointers wrap at the depth, which need not be a power of two
        always_ff @(posedge Clk_400) begin
                if (reset) begin
                        wrPtr <= '0;
                        rdPtr <= '0;
                        count <= '0;
                end else begin
                        if (doPush) begin
                                wrPtr <= (wrPtr == PtrWidth'(RspDepth - 1)) ? '0 : wrPtr + 1'b1;
                        end
                        if (doPop) begin
                                rdPtr <= (rdPtr == PtrWidth'(RspDepth - 1)) ? '0 : rdPtr + 1'b1;
                        end
                        // count unchanged on simultaneous push and pop
                        if (doPush && !doPop) begin
                                count <= count + 1'b1;
                        end else if (doPop && !doPush) begin
                                count <= count - 1'b1;
                        end
                end
        end

endmodule

// File: vlog.f
afuPkg.sv
mmioIngress.sv
afuCsr.sv
rspFifo.sv
rspEgress.sv
afuTop.sv
afuTb.sv
